/* include/regbridge_defines.svh */
//##################################################
// Width, register count, base address, read delay
// and identification word of the register bridge
//##################################################
`ifndef REGBRIDGE_DEFINES_SVH
`define REGBRIDGE_DEFINES_SVH

// AXI-Lite byte address and data widths
`define REGB_ADDR_WIDTH 32
`define REGB_DATA_WIDTH 32

// Number of 32-bit registers in the bank, register 0 included
`define REGB_REG_COUNT 16

// Byte address that maps to register 0
`define REGB_BASE_ADDRESS 32'h4000_0000

// Cycles from an issued read index to valid read data
`define REGB_READ_DELAY 2

// Constant returned by register 0
`define REGB_ID_VALUE 32'h5242_0100

`endif

/* hw/regbridge_pkg.sv */
//##################################################
// Shared types: bus vectors, channel structs and
// the skid buffer state
//##################################################
`default_nettype none

`include "regbridge_defines.svh"

package regbridge_pkg;

    // Plain vectors with a meaning on the bus
    typedef logic [`REGB_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [`REGB_DATA_WIDTH-1:0] axil_data_t;
    typedef logic [`REGB_DATA_WIDTH/8-1:0] axil_strb_t;
    typedef logic [1:0] axil_resp_t;

    // Word index, full width until the bank range check
    typedef logic [31:0] reg_index_t;

    localparam axil_resp_t AXIL_RESP_OKAY = 2'b00;

    // W channel payload
    typedef struct packed {
        axil_data_t data;
        axil_strb_t strb;
    } axil_w_t;

    // R channel payload
    typedef struct packed {
        axil_data_t data;
        axil_resp_t resp;
    } axil_r_t;

    // One strobed write towards the register bank
    typedef struct packed {
        reg_index_t index;
        axil_data_t data;
        axil_strb_t strb;
    } reg_write_t;

    typedef enum logic {
        skid_empty,
        skid_full
    } skid_state_t;

endpackage

`default_nettype wire

/* hw/axil_skid_buffer.sv */
//##################################################
// One-entry skid buffer for a valid/ready channel
//##################################################
`timescale 1ns/100ps
`default_nettype none

module axil_skid_buffer #(
    parameter int DATA_WIDTH = 32,
    parameter bit REGISTER_OUTPUT = 1'b0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [DATA_WIDTH-1:0] out_data
);

    import regbridge_pkg::*;

    skid_state_t state;
    skid_state_t state_next;
    logic [DATA_WIDTH-1:0] skid_data;
    logic accept;
    // Output stage can take an item this cycle
    logic drain;

    assign accept = in_valid && in_ready;

    always_comb begin
        state_next = state;
        case (state)
            skid_empty: if (accept && !drain) state_next = skid_full;
            skid_full:  if (drain) state_next = skid_empty;
            default:    state_next = skid_empty;
        endcase
    end

    // in_ready comes straight from a flop
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= skid_empty;
            in_ready <= 1'b0;
        end else begin
            state <= state_next;
            in_ready <= (state_next == skid_empty);
        end
    end

    // Spare entry, loaded when the output stalls
    always_ff @(posedge clock) begin
        if (state == skid_empty && accept && !drain) begin
            skid_data <= in_data;
        end
    end

    generate
        if (REGISTER_OUTPUT) begin : g_registered
            assign drain = !out_valid || out_ready;

            always_ff @(posedge clock) begin
                if (!reset) begin
                    out_valid <= 1'b0;
                end else if (drain) begin
                    out_valid <= (state == skid_full) || accept;
                end
            end

            always_ff @(posedge clock) begin
                if (drain) begin
                    if (state == skid_full) begin
                        out_data <= skid_data;
                    end else if (accept) begin
                        out_data <= in_data;
                    end
                end
            end
        end else begin : g_passthrough
            // Input goes straight through while nothing is held
            assign drain = out_ready;
            assign out_valid = (state == skid_full) || accept;
            assign out_data = (state == skid_full) ? skid_data : in_data;
        end
    endgenerate

    // A stalled item must not change under the consumer
    stable_while_stalled : assert property (
        @(posedge clock) disable iff (!reset)
        out_valid && !out_ready |=> $stable(out_data)
    );

endmodule

`default_nettype wire

/* hw/axil_external_registers_cu.sv */
//##################################################
// AXI-Lite control unit: buffered request channels,
// address translation, B and R channel registers
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "regbridge_defines.svh"

module axil_external_registers_cu #(
    parameter regbridge_pkg::axil_addr_t BASE_ADDRESS = `REGB_BASE_ADDRESS,
    parameter bit REGISTERED_BUFFERS = 1'b0
) (
    input  logic                       clock,
    input  logic                       reset,
    // AXI-Lite slave side
    input  logic                       awvalid,
    output logic                       awready,
    input  regbridge_pkg::axil_addr_t  awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  regbridge_pkg::axil_w_t     w,
    output logic                       bvalid,
    input  logic                       bready,
    output regbridge_pkg::axil_resp_t  bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  regbridge_pkg::axil_addr_t  araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output regbridge_pkg::axil_r_t     r,
    // Register bank side
    output logic                       read_index_valid,
    output regbridge_pkg::reg_index_t  read_index,
    input  logic                       read_data_valid,
    input  regbridge_pkg::axil_data_t  read_data,
    output logic                       write_req_valid,
    output regbridge_pkg::reg_write_t  write_req
);

    import regbridge_pkg::*;

    logic aw_out_valid;
    axil_addr_t aw_addr;
    logic w_out_valid;
    axil_w_t w_buf;
    logic ar_out_valid;
    axil_addr_t ar_addr;

    logic b_free;
    logic write_fire;
    axil_addr_t write_offset;

    logic r_free;
    logic read_fire;
    logic read_pending;
    axil_addr_t read_offset;
    axil_data_t r_data;

    axil_skid_buffer #(
        .DATA_WIDTH($bits(axil_addr_t)),
        .REGISTER_OUTPUT(REGISTERED_BUFFERS)
    ) aw_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(awvalid),
        .in_ready(awready),
        .in_data(awaddr),
        .out_valid(aw_out_valid),
        .out_ready(write_fire),
        .out_data(aw_addr)
    );

    axil_skid_buffer #(
        .DATA_WIDTH($bits(axil_w_t)),
        .REGISTER_OUTPUT(REGISTERED_BUFFERS)
    ) w_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(wvalid),
        .in_ready(wready),
        .in_data(w),
        .out_valid(w_out_valid),
        .out_ready(write_fire),
        .out_data(w_buf)
    );

    axil_skid_buffer #(
        .DATA_WIDTH($bits(axil_addr_t)),
        .REGISTER_OUTPUT(REGISTERED_BUFFERS)
    ) ar_buffer (
        .clock(clock),
        .reset(reset),
        .in_valid(arvalid),
        .in_ready(arready),
        .in_data(araddr),
        .out_valid(ar_out_valid),
        .out_ready(read_fire),
        .out_data(ar_addr)
    );

    // Address and data leave the buffers together
    assign b_free = !bvalid || bready;
    assign write_fire = aw_out_valid && w_out_valid && b_free;
    assign write_offset = aw_addr - BASE_ADDRESS;

    assign write_req_valid = write_fire;
    assign write_req = '{
        index: reg_index_t'(write_offset >> 2),
        data:  w_buf.data,
        strb:  w_buf.strb
    };

    always_ff @(posedge clock) begin
        if (!reset) begin
            bvalid <= 1'b0;
        end else if (write_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign bresp = AXIL_RESP_OKAY;

    // At most one read in flight
    assign r_free = !rvalid || rready;
    assign read_fire = ar_out_valid && !read_pending && r_free;
    assign read_offset = ar_addr - BASE_ADDRESS;

    assign read_index_valid = read_fire;
    assign read_index = reg_index_t'(read_offset >> 2);

    always_ff @(posedge clock) begin
        if (!reset) begin
            read_pending <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (read_fire) begin
                read_pending <= 1'b1;
            end else if (read_data_valid) begin
                read_pending <= 1'b0;
            end

            if (read_data_valid) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (read_data_valid) begin
            r_data <= read_data;
        end
    end

    assign r = '{data: r_data, resp: AXIL_RESP_OKAY};

    // A stalled response stays up and keeps the next write waiting
    bvalid_held : assert property (
        @(posedge clock) disable iff (!reset)
        bvalid && !bready |=> bvalid && !$past(write_fire)
    );

    // Bank data only ever answers a read that was issued
    read_data_expected : assert property (
        @(posedge clock) disable iff (!reset)
        read_data_valid |-> read_pending
    );

endmodule

`default_nettype wire

/* hw/register_bank.sv */
//##################################################
// Register storage: strobed writes, read-only ID in
// register 0, fixed-delay read pipeline
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "regbridge_defines.svh"

module register_bank #(
    parameter int REG_COUNT = `REGB_REG_COUNT,
    parameter int READ_DELAY = `REGB_READ_DELAY
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      write_req_valid,
    input  regbridge_pkg::reg_write_t write_req,
    input  logic                      read_index_valid,
    input  regbridge_pkg::reg_index_t read_index,
    output logic                      read_data_valid,
    output regbridge_pkg::axil_data_t read_data
);

    import regbridge_pkg::*;

    localparam int INDEX_BITS = $clog2(REG_COUNT);

    // Register 0 has no storage, it is the ID word
    axil_data_t regs [1:REG_COUNT-1];
    axil_data_t read_word;
    logic write_hit;

    logic       valid_pipe [READ_DELAY];
    axil_data_t data_pipe [READ_DELAY];

    function automatic axil_data_t apply_strobe(
        input axil_data_t prior,
        input axil_data_t update,
        input axil_strb_t strb
    );
        axil_data_t merged;
        merged = prior;
        for (int k = 0; k < $bits(axil_strb_t); k++) begin
            if (strb[k]) begin
                merged[k*8 +: 8] = update[k*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign write_hit = write_req_valid
                    && (write_req.index != '0)
                    && (write_req.index < REG_COUNT);

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_hit) begin
            regs[write_req.index[INDEX_BITS-1:0]] <= apply_strobe(
                regs[write_req.index[INDEX_BITS-1:0]], write_req.data, write_req.strb);
        end
    end

    // Lookup for the first pipeline stage
    always_comb begin
        if (read_index == '0) begin
            read_word = `REGB_ID_VALUE;
        end else if (read_index < REG_COUNT) begin
            read_word = regs[read_index[INDEX_BITS-1:0]];
        end else begin
            read_word = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < READ_DELAY; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= read_index_valid;
            for (int i = 1; i < READ_DELAY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        data_pipe[0] <= read_word;
        for (int i = 1; i < READ_DELAY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign read_data_valid = valid_pipe[READ_DELAY-1];
    assign read_data = data_pipe[READ_DELAY-1];

    // Latency is fixed, the pipeline never stalls
    fixed_read_latency : assert property (
        @(posedge clock) disable iff (!reset)
        read_data_valid == $past(read_index_valid, READ_DELAY)
    );

endmodule

`default_nettype wire

/* hw/regbridge_top.sv */
//##################################################
// AXI-Lite register bridge top level
//##################################################
`timescale 1ns/100ps
`default_nettype none

module regbridge_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      awvalid,
    output logic                      awready,
    input  regbridge_pkg::axil_addr_t awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  regbridge_pkg::axil_w_t    w,
    output logic                      bvalid,
    input  logic                      bready,
    output regbridge_pkg::axil_resp_t bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  regbridge_pkg::axil_addr_t araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output regbridge_pkg::axil_r_t    r
);

    // Streams between the control unit and the bank
    logic                      read_index_valid;
    regbridge_pkg::reg_index_t read_index;
    logic                      read_data_valid;
    regbridge_pkg::axil_data_t read_data;
    logic                      write_req_valid;
    regbridge_pkg::reg_write_t write_req;

    axil_external_registers_cu cu (
        .clock(clock),
        .reset(reset),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr(awaddr),
        .wvalid(wvalid),
        .wready(wready),
        .w(w),
        .bvalid(bvalid),
        .bready(bready),
        .bresp(bresp),
        .arvalid(arvalid),
        .arready(arready),
        .araddr(araddr),
        .rvalid(rvalid),
        .rready(rready),
        .r(r),
        .read_index_valid(read_index_valid),
        .read_index(read_index),
        .read_data_valid(read_data_valid),
        .read_data(read_data),
        .write_req_valid(write_req_valid),
        .write_req(write_req)
    );

    register_bank bank (
        .clock(clock),
        .reset(reset),
        .write_req_valid(write_req_valid),
        .write_req(write_req),
        .read_index_valid(read_index_valid),
        .read_index(read_index),
        .read_data_valid(read_data_valid),
        .read_data(read_data)
    );

endmodule

`default_nettype wire

/* tb/regbridge_tb.sv */
//##################################################
// Table-driven testbench for the register bridge,
// AXI-Lite master tasks and a shadow register model
//##################################################
`timescale 1ns/100ps
`default_nettype none

`include "regbridge_defines.svh"

module regbridge_tb;

    import regbridge_pkg::*;

    localparam axil_resp_t OKAY = 2'b00;
    localparam int INDEX_BITS = $clog2(`REGB_REG_COUNT);
    localparam int CYCLES_PER_ENTRY = 40;

    typedef struct packed {
        logic       is_write;
        axil_addr_t addr;
        axil_data_t data;
        axil_strb_t strb;
        axil_data_t expected;
    } table_entry_t;

    logic       clock;
    logic       reset;
    logic       awvalid;
    logic       awready;
    axil_addr_t awaddr;
    logic       wvalid;
    logic       wready;
    axil_w_t    w;
    logic       bvalid;
    logic       bready;
    axil_resp_t bresp;
    logic       arvalid;
    logic       arready;
    axil_addr_t araddr;
    logic       rvalid;
    logic       rready;
    axil_r_t    r;

    table_entry_t entries[$];
    axil_data_t   shadow [`REGB_REG_COUNT];
    integer       seed = 32'h99be_431f;
    integer       error_count = 0;
    integer       check_count = 0;

    regbridge_top uut (
        .clock(clock),
        .reset(reset),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr(awaddr),
        .wvalid(wvalid),
        .wready(wready),
        .w(w),
        .bvalid(bvalid),
        .bready(bready),
        .bresp(bresp),
        .arvalid(arvalid),
        .arready(arready),
        .araddr(araddr),
        .rvalid(rvalid),
        .rready(rready),
        .r(r)
    );

    always #4 clock = ~clock;

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Shadow model of the bank with word indices relative to the base
    function automatic axil_addr_t word_index(input axil_addr_t addr);
        axil_addr_t offset;
        offset = addr - `REGB_BASE_ADDRESS;
        return offset >> 2;
    endfunction

    function automatic axil_data_t shadow_read(input axil_addr_t addr);
        axil_addr_t idx;
        idx = word_index(addr);
        if (idx == 0) begin
            return `REGB_ID_VALUE;
        end else if (idx < `REGB_REG_COUNT) begin
            return shadow[idx[INDEX_BITS-1:0]];
        end
        return '0;
    endfunction

    function automatic void add_write(input axil_addr_t addr, input axil_data_t data,
                                      input axil_strb_t strb);
        axil_addr_t idx;
        axil_data_t mask;
        idx = word_index(addr);
        for (int k = 0; k < 4; k++) begin
            mask[k*8 +: 8] = {8{strb[k]}};
        end
        if (idx != 0 && idx < `REGB_REG_COUNT) begin
            shadow[idx[INDEX_BITS-1:0]] = (shadow[idx[INDEX_BITS-1:0]] & ~mask) | (data & mask);
        end
        entries.push_back('{is_write: 1'b1, addr: addr, data: data, strb: strb, expected: '0});
    endfunction

    function automatic void add_read(input axil_addr_t addr);
        entries.push_back('{is_write: 1'b0, addr: addr, data: '0, strb: '0,
                            expected: shadow_read(addr)});
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] rdata;
        for (int i = 0; i < `REGB_REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        // Reset values of every register
        for (int i = 0; i < `REGB_REG_COUNT; i++) begin
            add_read(`REGB_BASE_ADDRESS + 4 * i);
        end
        add_write(32'h4000_000c, 32'hdead_beef, 4'b1111);
        add_read(32'h4000_000c);
        // Byte strobes on register 5
        add_write(32'h4000_0014, 32'h1234_5678, 4'b1111);
        add_write(32'h4000_0014, 32'haabb_ccdd, 4'b0101);
        add_read(32'h4000_0014);
        add_write(32'h4000_0014, 32'h9900_0000, 4'b1000);
        add_read(32'h4000_0014);
        // ID register is read only
        add_write(`REGB_BASE_ADDRESS, 32'hffff_ffff, 4'b1111);
        add_read(`REGB_BASE_ADDRESS);
        // Outside the register range
        add_write(32'h4000_0040, 32'h0bad_f00d, 4'b1111);
        add_write(32'h4000_0400, 32'hcafe_0001, 4'b1111);
        add_read(32'h4000_0040);
        add_read(32'h4000_0400);
        for (int i = 0; i < 10; i++) begin
            rnd = $random(seed);
            rdata = $random(seed);
            add_write(`REGB_BASE_ADDRESS + {26'b0, rnd[3:0], 2'b00}, rdata, rnd[7:4]);
            add_read(`REGB_BASE_ADDRESS + {26'b0, rnd[3:0], 2'b00});
        end
        for (int i = 0; i < `REGB_REG_COUNT; i++) begin
            add_read(`REGB_BASE_ADDRESS + 4 * i);
        end
    endtask

    task automatic write_word(input axil_addr_t addr, input axil_data_t wdata,
                              input axil_strb_t wstrb);
        logic aw_done;
        logic w_done;
        logic aw_hs;
        logic w_hs;
        logic held;
        logic b_done;
        logic [31:0] rnd;
        aw_done = 1'b0;
        w_done = 1'b0;
        awaddr = addr;
        w = '{data: wdata, strb: wstrb};
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!(aw_done && w_done)) begin
            // Outputs are stable until the next edge
            aw_hs = awvalid && awready;
            w_hs = wvalid && wready;
            @(posedge clock);
            #1;
            if (aw_hs) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
        end
        held = 1'b0;
        b_done = 1'b0;
        while (!b_done) begin
            rnd = $random(seed);
            bready = rnd[0];
            if (held) begin
                check_flag("bvalid", 1'b1, bvalid);
            end
            held = bvalid && !bready;
            if (bvalid && bready) begin
                check_word("bresp", {30'b0, OKAY}, {30'b0, bresp});
                b_done = 1'b1;
            end
            @(posedge clock);
            #1;
        end
        bready = 1'b0;
        // A second response would show up here
        check_flag("bvalid", 1'b0, bvalid);
    endtask

    task automatic read_word(input axil_addr_t addr, input axil_data_t expected);
        logic ar_hs;
        logic held;
        logic r_done;
        axil_data_t held_word;
        logic [31:0] rnd;
        araddr = addr;
        arvalid = 1'b1;
        ar_hs = 1'b0;
        while (!ar_hs) begin
            ar_hs = arvalid && arready;
            @(posedge clock);
            #1;
        end
        arvalid = 1'b0;
        held = 1'b0;
        held_word = '0;
        r_done = 1'b0;
        while (!r_done) begin
            rnd = $random(seed);
            rready = rnd[0];
            if (held) begin
                check_flag("rvalid", 1'b1, rvalid);
                check_word("rdata held", held_word, r.data);
            end
            held = rvalid && !rready;
            held_word = r.data;
            if (rvalid && rready) begin
                check_word("rdata", expected, r.data);
                check_word("rresp", {30'b0, OKAY}, {30'b0, r.resp});
                r_done = 1'b1;
            end
            @(posedge clock);
            #1;
        end
        rready = 1'b0;
        check_flag("rvalid", 1'b0, rvalid);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        w = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        build_table();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;
        check_flag("bvalid", 1'b0, bvalid);
        check_flag("rvalid", 1'b0, rvalid);
        check_flag("awready", 1'b0, awready);
        check_flag("wready", 1'b0, wready);
        check_flag("arready", 1'b0, arready);
        foreach (entries[i]) begin
            if (entries[i].is_write) begin
                write_word(entries[i].addr, entries[i].data, entries[i].strb);
            end else begin
                read_word(entries[i].addr, entries[i].expected);
            end
        end
        repeat (4) @(posedge clock);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog scaled by the number of table entries
    initial begin
        #1;
        repeat (entries.size() * CYCLES_PER_ENTRY) @(posedge clock);
        $display("timeout: the table was not done after %0d cycles",
                 entries.size() * CYCLES_PER_ENTRY);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hw/regbridge_pkg.sv
hw/axil_skid_buffer.sv
hw/axil_external_registers_cu.sv
hw/register_bank.sv
hw/regbridge_top.sv
tb/regbridge_tb.sv

/* Makefile */
# Verilator build and run of the register bridge testbench

VERILATOR ?= verilator
TOP       ?= regbridge_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Fails unless the pass message shows up in the output
run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
